/* Bender.yml */
package:
  name: fe_capture

sources:
  - source/fe_pkg.sv
  - source/fe_cfg_pkg.sv
  - source/fe_event_detect.sv
  - source/fe_capture_main.sv
  - source/fe_fifo.sv
  - source/fe_arm_ctrl.sv
  - source/fe_top.sv
  - target: test
    files:
      - dv/fe_tb.sv

/* dv/fe_tb.sv */
// directed testbench for the front-end capture subsystem with a queue reference model
`default_nettype none

module fe_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 2000;

    logic                fe_clk = 1'b0;
    logic                reset_i;
    logic                target_strobe_i;
    fe_pkg::fe_byte_t    target_byte_i;
    fe_pkg::fe_stat_t    target_stat_i;
    logic                capture_while_trig_i;
    logic                count_writes_i;
    fe_cfg_pkg::fe_len_t capture_len_i;
    fe_pkg::fe_time_t    max_short_timestamp_i;
    fe_pkg::fe_time_t    max_timestamp_i;
    logic                timestamps_disable_i;
    logic                arm_i;
    logic                trigger_i;
    logic                rd_i;
    logic                rd_empty_o;
    fe_pkg::fe_cmd_e     rd_cmd_o;
    fe_pkg::fe_time_t    rd_time_o;
    fe_pkg::fe_byte_t    rd_byte_o;
    logic                overflow_o;
    logic                capturing_o;
    logic                capture_done_o;

    int          cyc = 0;
    int          last_at;
    logic [15:0] lfsr = 16'd18218;
    // predicted records as {time valid, cmd, time, byte}
    logic [26:0] exp_q[$];

    always #20 fe_clk = ~fe_clk;

    // posedge count, read on the falling edge
    always @(posedge fe_clk) cyc <= cyc + 1;

    fe_top UUT (
        .fe_clk                (fe_clk),
        .reset_i               (reset_i),
        .target_strobe_i       (target_strobe_i),
        .target_byte_i         (target_byte_i),
        .target_stat_i         (target_stat_i),
        .capture_while_trig_i  (capture_while_trig_i),
        .count_writes_i        (count_writes_i),
        .capture_len_i         (capture_len_i),
        .max_short_timestamp_i (max_short_timestamp_i),
        .max_timestamp_i       (max_timestamp_i),
        .timestamps_disable_i  (timestamps_disable_i),
        .arm_i                 (arm_i),
        .trigger_i             (trigger_i),
        .rd_i                  (rd_i),
        .rd_empty_o            (rd_empty_o),
        .rd_cmd_o              (rd_cmd_o),
        .rd_time_o             (rd_time_o),
        .rd_byte_o             (rd_byte_o),
        .overflow_o            (overflow_o),
        .capturing_o           (capturing_o),
        .capture_done_o        (capture_done_o)
    );

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // galois LFSR, one step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic die(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    // records for an event that the engine sees after posedge at
    task automatic expect_event(input int at, input fe_pkg::fe_cmd_e cmd,
                                input fe_pkg::fe_byte_t b);
        int gap;
        gap = at - last_at;
        last_at = at;
        if (!timestamps_disable_i && gap > max_short_timestamp_i) begin
            exp_q.push_back({1'b1, fe_pkg::TIME, fe_pkg::fe_time_t'(gap), 8'h00});
            exp_q.push_back({1'b1, cmd, 16'h0000, b});
        end else begin
            exp_q.push_back({!timestamps_disable_i, cmd, fe_pkg::fe_time_t'(gap), b});
        end
    endtask

    // one target event, gap cycles after the previous one
    task automatic send_event(input int gap, input logic strobe, input fe_pkg::fe_byte_t b,
                              input fe_pkg::fe_stat_t stat, input logic stored);
        logic changed;
        repeat (gap - 1) @(negedge fe_clk);
        changed = (stat != target_stat_i);
        target_strobe_i = strobe;
        target_byte_i   = b;
        target_stat_i   = stat;
        if (stored && strobe) begin
            expect_event(cyc + 1, fe_pkg::DATA, b);
        end
        // a colliding status change follows the byte by one cycle
        if (stored && changed) begin
            expect_event(strobe ? cyc + 2 : cyc + 1, fe_pkg::STAT, fe_pkg::fe_byte_t'(stat));
        end
        @(negedge fe_clk);
        target_strobe_i = 1'b0;
    endtask

    task automatic start_capture();
        int n;
        arm_i     = 1'b1;
        trigger_i = 1'b1;
        @(negedge fe_clk);
        arm_i = 1'b0;
        n = 0;
        do begin
            @(negedge fe_clk);
            n++;
        end while (!capturing_o && n < TIMEOUT);
        if (!capturing_o) die("timeout: capture did not start after arm and trigger");
        assert (!capture_done_o)
            else die($sformatf("Fail at %0t: capture_done_o high while capturing", $time));
        exp_q.delete();
        last_at = cyc;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!capture_done_o && n < TIMEOUT) begin
            @(negedge fe_clk);
            n++;
        end
        if (!capture_done_o) die("timeout: capture never finished");
    endtask

    task automatic wait_record();
        int n;
        n = 0;
        while (rd_empty_o && n < TIMEOUT) begin
            @(negedge fe_clk);
            n++;
        end
        if (rd_empty_o) die("timeout: an expected record never reached the FIFO");
    endtask

    // pops every predicted record and compares the head
    task automatic check_records(input logic check_empty);
        logic [26:0] rec;
        logic        ok;
        while (exp_q.size() > 0) begin
            rec = exp_q.pop_front();
            wait_record();
            ok = (rd_cmd_o == rec[25:24]) && (!rec[26] || rd_time_o == rec[23:8]) &&
                 (rec[25:24] == fe_pkg::TIME || rd_byte_o == rec[7:0]);
            assert (ok) else die($sformatf(
                "Fail at %0t: got cmd %0d time %0d byte %02h, expected cmd %0d time %0d byte %02h",
                $time, rd_cmd_o, rd_time_o, rd_byte_o, rec[25:24], rec[23:8], rec[7:0]));
            rd_i = 1'b1;
            @(negedge fe_clk);
            rd_i = 1'b0;
        end
        if (check_empty) begin
            // well past the three-cycle target to FIFO path
            repeat (8) @(negedge fe_clk);
            assert (rd_empty_o)
                else die($sformatf("Fail at %0t: FIFO holds an unexpected record", $time));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        @(negedge fe_clk);
        assert (rd_empty_o && capture_done_o && !capturing_o && !overflow_o)
            else die($sformatf("Fail at %0t: wrong status after reset", $time));
        start_capture();
    endtask

    task automatic random_bytes();
        int gap;
        int b;
        start_capture();
        for (int i = 0; i < 12; i++) begin
            gap = 1 + rand_bits(3);
            b   = rand_bits(8);
            send_event(gap, 1'b1, fe_pkg::fe_byte_t'(b), target_stat_i, 1'b1);
        end
        check_records(1'b1);
    endtask

    task automatic status_events();
        start_capture();
        send_event(3, 1'b0, 8'h00, 2'b01, 1'b1);
        send_event(4, 1'b1, 8'h5A, 2'b10, 1'b1);
        send_event(3, 1'b0, 8'h00, 2'b11, 1'b1);
        check_records(1'b1);
    endtask

    task automatic timestamps();
        start_capture();
        send_event(20, 1'b1, 8'hA1, target_stat_i, 1'b1);
        send_event(3, 1'b1, 8'hA2, target_stat_i, 1'b1);
        send_event(9, 1'b1, 8'hA3, target_stat_i, 1'b1);
        check_records(1'b1);
        // idle spans up to the maximum
        max_timestamp_i = 16'd20;
        start_capture();
        exp_q.push_back({1'b1, fe_pkg::TIME, 16'd20, 8'h00});
        exp_q.push_back({1'b1, fe_pkg::TIME, 16'd20, 8'h00});
        check_records(1'b0);
        // no TIME records at all
        timestamps_disable_i = 1'b1;
        max_timestamp_i      = 16'd30;
        start_capture();
        send_event(40, 1'b1, 8'hB1, target_stat_i, 1'b1);
        send_event(40, 1'b1, 8'hB2, target_stat_i, 1'b1);
        check_records(1'b1);
        timestamps_disable_i = 1'b0;
        max_timestamp_i      = 16'hFFFF;
    endtask

    task automatic count_writes();
        count_writes_i = 1'b1;
        capture_len_i  = 24'd5;
        start_capture();
        for (int i = 0; i < 8; i++) begin
            send_event(2, 1'b1, fe_pkg::fe_byte_t'(8'hC0 + i), target_stat_i, i < 5);
        end
        wait_done();
        check_records(1'b1);
        count_writes_i = 1'b0;
        capture_len_i  = '0;
        // a new arm throws away what is stored
        start_capture();
        send_event(2, 1'b1, 8'hD0, target_stat_i, 1'b0);
        wait_record();
        start_capture();
        assert (rd_empty_o) else die($sformatf("Fail at %0t: FIFO not empty after arm", $time));
    endtask

    task automatic trigger_and_overflow();
        int depth;
        int b;
        depth = 2 ** UUT.FIFO_ADDR_WIDTH;
        capture_while_trig_i = 1'b1;
        start_capture();
        for (int i = 0; i < 4; i++) begin
            b = rand_bits(8);
            send_event(2, 1'b1, fe_pkg::fe_byte_t'(b), target_stat_i, 1'b1);
        end
        repeat (3) @(negedge fe_clk);
        trigger_i = 1'b0;
        send_event(1, 1'b1, 8'hEE, target_stat_i, 1'b0);
        wait_done();
        send_event(2, 1'b1, 8'hEF, target_stat_i, 1'b0);
        check_records(1'b1);
        capture_while_trig_i = 1'b0;

        ////////////////////////////////////////////////////////////////////
        // back-to-back bytes until the FIFO overflows
        ////////////////////////////////////////////////////////////////////
        start_capture();
        for (int i = 0; i < depth + 6; i++) begin
            b = rand_bits(8);
            send_event(1, 1'b1, fe_pkg::fe_byte_t'(b), target_stat_i, 1'b1);
        end
        wait_done();
        assert (overflow_o) else die($sformatf("Fail at %0t: overflow_o not set", $time));
        while (exp_q.size() > depth) begin
            void'(exp_q.pop_back());
        end
        check_records(1'b1);
        start_capture();
        assert (!overflow_o && rd_empty_o)
            else die($sformatf("Fail at %0t: arm did not clear overflow", $time));
    endtask

    initial begin
        reset_i               = 1'b1;
        target_strobe_i       = 1'b0;
        target_byte_i         = '0;
        target_stat_i         = '0;
        capture_while_trig_i  = 1'b0;
        count_writes_i        = 1'b0;
        capture_len_i         = '0;
        max_short_timestamp_i = 16'd8;
        max_timestamp_i       = 16'hFFFF;
        timestamps_disable_i  = 1'b0;
        arm_i                 = 1'b0;
        trigger_i             = 1'b0;
        rd_i                  = 1'b0;
        last_at               = 0;
        repeat (4) @(negedge fe_clk);
        reset_i = 1'b0;

        reset_state();
        random_bytes();
        status_events();
        timestamps();
        count_writes();
        trigger_and_overflow();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
source/fe_pkg.sv
source/fe_cfg_pkg.sv
source/fe_event_detect.sv
source/fe_capture_main.sv
source/fe_fifo.sv
source/fe_arm_ctrl.sv
source/fe_top.sv
dv/fe_tb.sv

/* source/fe_arm_ctrl.sv */
// arm controller sequencing flush, trigger wait and end of capture
`default_nettype none

module fe_arm_ctrl (
    input  wire     fe_clk,
    input  wire     reset_i,
    input  wire     arm_i,
    input  wire     trigger_i,
    input  wire     capturing_i,
    output logic    flush_o,
    output logic    clear_o,
    output logic    capture_enable_o,
    output logic    capture_done_o
);

    fe_cfg_pkg::fe_arm_state_e state;
    fe_cfg_pkg::fe_arm_state_e next_state;
    logic                      seen_r;

    // arm restarts from anywhere
    always_comb begin
        next_state = state;
        if (arm_i) begin
            next_state = fe_cfg_pkg::ARMED;
        end else begin
            case (state)
                fe_cfg_pkg::ARMED: begin
                    if (trigger_i) begin
                        next_state = fe_cfg_pkg::CAPTURE;
                    end
                end
                fe_cfg_pkg::CAPTURE: begin
                    // end once capture has run and then stopped
                    if (seen_r && !capturing_i) begin
                        next_state = fe_cfg_pkg::DONE;
                    end
                end
                default: begin
                    next_state = state;
                end
            endcase
        end
    end

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            state   <= fe_cfg_pkg::IDLE;
            seen_r  <= 1'b0;
            flush_o <= 1'b0;
            clear_o <= 1'b0;
        end else begin
            state   <= next_state;
            flush_o <= arm_i;
            clear_o <= arm_i;
            if (arm_i || state != fe_cfg_pkg::CAPTURE) begin
                seen_r <= 1'b0;
            end else if (capturing_i) begin
                seen_r <= 1'b1;
            end
        end
    end

    assign capture_enable_o = (state == fe_cfg_pkg::CAPTURE);
    assign capture_done_o   = (state == fe_cfg_pkg::IDLE) || (state == fe_cfg_pkg::DONE);

endmodule

`default_nettype wire

/* source/fe_capture_main.sv */
// capture engine building timestamped DATA and TIME records from events
`default_nettype none

module fe_capture_main (
    input  wire                         fe_clk,
    input  wire                         reset_i,
    input  wire                         event_i,
    input  wire fe_pkg::fe_cmd_e        cmd_i,
    input  wire fe_pkg::fe_byte_t       byte_i,
    input  wire                         capture_enable_i,
    input  wire                         clear_i,
    input  wire                         trigger_i,
    input  wire                         capture_while_trig_i,
    input  wire                         count_writes_i,
    input  wire fe_cfg_pkg::fe_len_t    capture_len_i,
    input  wire fe_pkg::fe_time_t       max_short_timestamp_i,
    input  wire fe_pkg::fe_time_t       max_timestamp_i,
    input  wire                         timestamps_disable_i,
    input  wire                         fifo_full_i,
    input  wire                         fifo_overflow_i,
    output logic                        wr_o,
    output fe_pkg::fe_cmd_e             wr_cmd_o,
    output fe_pkg::fe_time_t            wr_time_o,
    output fe_pkg::fe_byte_t            wr_byte_o,
    output logic                        capturing_o
);

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_DATA = 2'd1,
        S_TIME = 2'd2
    } state_e;

    state_e              state;
    state_e              next_state;
    fe_pkg::fe_time_t    ctr;
    fe_pkg::fe_time_t    gap_r;
    fe_pkg::fe_cmd_e     cmd_r;
    fe_pkg::fe_byte_t    byte_r;
    fe_cfg_pkg::fe_len_t count;
    logic                ev_r;
    logic                long_r;
    logic                early_time;
    logic                long_gap;
    logic                idle_limit;
    logic                len_ok;

    //////////////////////////////////////////////////////////////////////
    // gap counter
    //////////////////////////////////////////////////////////////////////

    // gap seen by an event in this cycle
    assign long_gap   = !timestamps_disable_i && (ctr > max_short_timestamp_i);
    assign idle_limit = (ctr >= max_timestamp_i);

    // zero at capture start, restarts on every event and at the idle limit
    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            ctr <= '0;
        end else if (!capture_enable_i) begin
            ctr <= '0;
        end else if (event_i || idle_limit) begin
            ctr <= fe_pkg::fe_time_t'(1);
        end else begin
            ctr <= ctr + fe_pkg::fe_time_t'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // event pipeline and record FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            ev_r   <= 1'b0;
            long_r <= 1'b0;
        end else begin
            ev_r   <= event_i;
            long_r <= early_time;
        end
    end

    always_ff @(posedge fe_clk) begin
        gap_r  <= ctr;
        cmd_r  <= cmd_i;
        byte_r <= byte_i;
    end

    // state holds the record written in this cycle
    // a long gap writes its TIME record straight from event_i, one cycle
    // ahead of the data record, so back-to-back events keep their spacing
    always_comb begin
        next_state = S_IDLE;
        early_time = 1'b0;
        if (ev_r && capturing_o) begin
            next_state = S_DATA;
        end else if (event_i && long_gap && capturing_o) begin
            next_state = S_TIME;
            early_time = 1'b1;
        end else if (!event_i && idle_limit && !timestamps_disable_i && capturing_o) begin
            next_state = S_TIME;
        end
    end

    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign wr_o = (state != S_IDLE);

    // record payload, loaded along with the state
    always_ff @(posedge fe_clk) begin
        if (next_state == S_DATA) begin
            wr_cmd_o  <= cmd_r;
            wr_time_o <= long_r ? fe_pkg::fe_time_t'(0) : gap_r;
            wr_byte_o <= byte_r;
        end else begin
            wr_cmd_o  <= fe_pkg::TIME;
            wr_time_o <= ctr;
            wr_byte_o <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // capture length accounting
    //////////////////////////////////////////////////////////////////////

    // in count-writes mode a record counts when it is decided
    always_ff @(posedge fe_clk) begin
        if (reset_i || clear_i) begin
            count <= '0;
        end else if (count_writes_i ? (next_state != S_IDLE) : capture_enable_i) begin
            count <= count + fe_cfg_pkg::fe_len_t'(1);
        end
    end

    assign len_ok = (count < capture_len_i) || (capture_len_i == '0);

    assign capturing_o = capture_enable_i && !fifo_full_i && !fifo_overflow_i &&
                         (capture_while_trig_i ? trigger_i : len_ok);

endmodule

`default_nettype wire

/* source/fe_cfg_pkg.sv */
// capture configuration types and arm controller states
`default_nettype none

package fe_cfg_pkg;

    // capture length in records or enable cycles, zero for no limit
    typedef logic [23:0] fe_len_t;

    // arm controller states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ARMED   = 2'd1,
        CAPTURE = 2'd2,
        DONE    = 2'd3
    } fe_arm_state_e;

endpackage

`default_nettype wire

/* source/fe_event_detect.sv */
// event detector turning target byte strobes and status changes into event strobes
`default_nettype none

module fe_event_detect (
    input  wire                     fe_clk,
    input  wire                     reset_i,
    input  wire                     target_strobe_i,
    input  wire fe_pkg::fe_byte_t   target_byte_i,
    input  wire fe_pkg::fe_stat_t   target_stat_i,
    output logic                    event_o,
    output fe_pkg::fe_cmd_e         cmd_o,
    output fe_pkg::fe_byte_t        byte_o
);

    fe_pkg::fe_stat_t stat_r;
    fe_pkg::fe_stat_t pend_stat;
    logic             pend;
    logic             stat_change;

    assign stat_change = (target_stat_i != stat_r);

    // strobe and pending status event
    // lines are sampled during reset so release does not fire a STAT event
    always_ff @(posedge fe_clk) begin
        if (reset_i) begin
            event_o <= 1'b0;
            pend    <= 1'b0;
            stat_r  <= target_stat_i;
        end else begin
            stat_r  <= target_stat_i;
            event_o <= target_strobe_i | pend | stat_change;
            if (target_strobe_i) begin
                // byte wins, status waits one cycle
                if (stat_change) begin
                    pend <= 1'b1;
                end
            end else if (pend) begin
                pend <= stat_change;
            end
        end
    end

    // event payload
    always_ff @(posedge fe_clk) begin
        if (stat_change) begin
            pend_stat <= target_stat_i;
        end
        if (target_strobe_i) begin
            cmd_o  <= fe_pkg::DATA;
            byte_o <= target_byte_i;
        end else if (pend) begin
            cmd_o  <= fe_pkg::STAT;
            byte_o <= fe_pkg::fe_byte_t'(pend_stat);
        end else begin
            cmd_o  <= fe_pkg::STAT;
            byte_o <= fe_pkg::fe_byte_t'(target_stat_i);
        end
    end

endmodule

`default_nettype wire

/* source/fe_fifo.sv */
// first-word-fall-through record FIFO with flush and sticky overflow block
`default_nettype none

module fe_fifo #(
    parameter int FIFO_ADDR_WIDTH = 6
) (
    input  wire                     fe_clk,
    input  wire                     reset_i,
    input  wire                     flush_i,
    input  wire                     wr_i,
    input  wire fe_pkg::fe_cmd_e    wr_cmd_i,
    input  wire fe_pkg::fe_time_t   wr_time_i,
    input  wire fe_pkg::fe_byte_t   wr_byte_i,
    input  wire                     rd_i,
    output logic                    full_o,
    output logic                    empty_o,
    output logic                    overflow_o,
    output fe_pkg::fe_cmd_e         rd_cmd_o,
    output fe_pkg::fe_time_t        rd_time_o,
    output fe_pkg::fe_byte_t        rd_byte_o
);

    localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

    fe_pkg::fe_rec_t                    mem [DEPTH];
    logic [FIFO_ADDR_WIDTH:0]           wr_ptr;
    logic [FIFO_ADDR_WIDTH:0]           rd_ptr;
    logic [$bits(fe_pkg::fe_cmd_e)-1:0] head_cmd;
    logic                               wr_en;
    logic                               rd_en;

    // extra pointer bit tells full from empty
    assign empty_o = (wr_ptr == rd_ptr);
    assign full_o  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                     (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

    // after an overflow nothing more goes in until flush
    assign wr_en = wr_i && !full_o && !overflow_o;
    assign rd_en = rd_i && !empty_o;

    //////////////////////////////////////////////////////////////////////
    // pointers and overflow flag
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge fe_clk) begin
        if (reset_i || flush_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_i && full_o) begin
                overflow_o <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage and head record
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge fe_clk) begin
        if (wr_en) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= {wr_cmd_i, wr_time_i, wr_byte_i};
        end
    end

    // head shows without a read, next one a cycle after rd_i
    assign {head_cmd, rd_time_o, rd_byte_o} = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
    assign rd_cmd_o = fe_pkg::fe_cmd_e'(head_cmd);

endmodule

`default_nettype wire

/* source/fe_pkg.sv */
// record format shared by the capture datapath, the FIFO and the host read port
`default_nettype none

package fe_pkg;

    //////////////////////////////////////////////////////////////////////
    // record fields
    //////////////////////////////////////////////////////////////////////

    // timestamp in fe_clk cycles
    typedef logic [15:0] fe_time_t;

    // payload byte of a record
    typedef logic [7:0] fe_byte_t;

    // target status lines
    typedef logic [1:0] fe_stat_t;

    // record command
    typedef enum logic [1:0] {
        DATA = 2'd0,
        STAT = 2'd1,
        TIME = 2'd2
    } fe_cmd_e;

    //////////////////////////////////////////////////////////////////////
    // packed record as held in the FIFO
    //////////////////////////////////////////////////////////////////////

    // command on top, then time, byte at the bottom
    localparam int FE_REC_WIDTH = $bits(fe_cmd_e) + $bits(fe_time_t) + $bits(fe_byte_t);

    typedef logic [FE_REC_WIDTH-1:0] fe_rec_t;

endpackage

`default_nettype wire

/* source/fe_top.sv */
// front-end capture subsystem top level with detector, engine, FIFO and arm control
`default_nettype none

module fe_top #(
    parameter int FIFO_ADDR_WIDTH = 6
) (
    input  wire                         fe_clk,
    input  wire                         reset_i,
    // target interface
    input  wire                         target_strobe_i,
    input  wire fe_pkg::fe_byte_t       target_byte_i,
    input  wire fe_pkg::fe_stat_t       target_stat_i,
    // capture configuration
    input  wire                         capture_while_trig_i,
    input  wire                         count_writes_i,
    input  wire fe_cfg_pkg::fe_len_t    capture_len_i,
    input  wire fe_pkg::fe_time_t       max_short_timestamp_i,
    input  wire fe_pkg::fe_time_t       max_timestamp_i,
    input  wire                         timestamps_disable_i,
    // control
    input  wire                         arm_i,
    input  wire                         trigger_i,
    input  wire                         rd_i,
    // host read port and status
    output wire                         rd_empty_o,
    output wire fe_pkg::fe_cmd_e        rd_cmd_o,
    output wire fe_pkg::fe_time_t       rd_time_o,
    output wire fe_pkg::fe_byte_t       rd_byte_o,
    output wire                         overflow_o,
    output wire                         capturing_o,
    output wire                         capture_done_o
);

    wire                   ev;
    wire fe_pkg::fe_cmd_e  ev_cmd;
    wire fe_pkg::fe_byte_t ev_byte;
    wire                   wr;
    wire fe_pkg::fe_cmd_e  wr_cmd;
    wire fe_pkg::fe_time_t wr_time;
    wire fe_pkg::fe_byte_t wr_byte;
    wire                   fifo_full;
    wire                   flush;
    wire                   clear;
    wire                   capture_enable;

    fe_event_detect u_event_detect (
        .fe_clk          (fe_clk),
        .reset_i         (reset_i),
        .target_strobe_i (target_strobe_i),
        .target_byte_i   (target_byte_i),
        .target_stat_i   (target_stat_i),
        .event_o         (ev),
        .cmd_o           (ev_cmd),
        .byte_o          (ev_byte)
    );

    fe_capture_main u_capture_main (
        .fe_clk                (fe_clk),
        .reset_i               (reset_i),
        .event_i               (ev),
        .cmd_i                 (ev_cmd),
        .byte_i                (ev_byte),
        .capture_enable_i      (capture_enable),
        .clear_i               (clear),
        .trigger_i             (trigger_i),
        .capture_while_trig_i  (capture_while_trig_i),
        .count_writes_i        (count_writes_i),
        .capture_len_i         (capture_len_i),
        .max_short_timestamp_i (max_short_timestamp_i),
        .max_timestamp_i       (max_timestamp_i),
        .timestamps_disable_i  (timestamps_disable_i),
        .fifo_full_i           (fifo_full),
        .fifo_overflow_i       (overflow_o),
        .wr_o                  (wr),
        .wr_cmd_o              (wr_cmd),
        .wr_time_o             (wr_time),
        .wr_byte_o             (wr_byte),
        .capturing_o           (capturing_o)
    );

    fe_fifo #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo (
        .fe_clk     (fe_clk),
        .reset_i    (reset_i),
        .flush_i    (flush),
        .wr_i       (wr),
        .wr_cmd_i   (wr_cmd),
        .wr_time_i  (wr_time),
        .wr_byte_i  (wr_byte),
        .rd_i       (rd_i),
        .full_o     (fifo_full),
        .empty_o    (rd_empty_o),
        .overflow_o (overflow_o),
        .rd_cmd_o   (rd_cmd_o),
        .rd_time_o  (rd_time_o),
        .rd_byte_o  (rd_byte_o)
    );

    fe_arm_ctrl u_arm_ctrl (
        .fe_clk           (fe_clk),
        .reset_i          (reset_i),
        .arm_i            (arm_i),
        .trigger_i        (trigger_i),
        .capturing_i      (capturing_o),
        .flush_o          (flush),
        .clear_o          (clear),
        .capture_enable_o (capture_enable),
        .capture_done_o   (capture_done_o)
    );

endmodule

`default_nettype wire
